/* Bender.yml */
package:
  name: dsp_datapath

sources:
  - dsp_pkg.sv
  - dsp_cfg_regs.sv
  - ffe_slicer.sv
  - channel_error.sv
  - sliding_detector.sv
  - dsp_datapath_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_dsp_datapath.sv

/* channel_error.sv */
`timescale 1ns/1ps

module channel_error (
    input  logic                                                          clk,
    input  logic                                                          rst_i,
    input  dsp_pkg::code_t   [dsp_pkg::lanes-1:0]                         codes_i,
    input  logic             [dsp_pkg::lanes-1:0]                         bits_i,
    input  dsp_pkg::chan_t   [dsp_pkg::lanes-1:0][dsp_pkg::chan_taps-1:0] chan_i,
    input  dsp_pkg::shift_t                                               chan_shift_i,
    output dsp_pkg::err_t    [dsp_pkg::lanes-1:0]                         error_o
);

    // Codes arrive already registered once at the top
    // Two more stages bring them level with the bit register in the FFE
    dsp_pkg::code_t [dsp_pkg::lanes-1:0] codes_d1_q;
    dsp_pkg::code_t [dsp_pkg::lanes-1:0] codes_d2_q;

    // Last bit of the previous word feeds the lane 0 post-cursor
    logic last_bit_q;

    logic [dsp_pkg::lanes-1:0] prev_bits;

    dsp_pkg::err_t [dsp_pkg::lanes-1:0] err_d;

    always_comb begin
        prev_bits[0] = last_bit_q;
        for (int l = 1; l < dsp_pkg::lanes; l++) begin
            prev_bits[l] = bits_i[l-1];
        end
    end

    always_comb begin
        dsp_pkg::chan_t  c0;
        dsp_pkg::chan_t  c1;
        dsp_pkg::ecode_t t0;
        dsp_pkg::ecode_t t1;
        dsp_pkg::ecode_t ecode;

        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            c0 = chan_i[l][0];
            c1 = chan_i[l][1];

            // Bit 1 maps to +1, bit 0 to -1
            t0 = bits_i[l]    ? dsp_pkg::ecode_t'(c0) : -dsp_pkg::ecode_t'(c0);
            t1 = prev_bits[l] ? dsp_pkg::ecode_t'(c1) : -dsp_pkg::ecode_t'(c1);

            ecode    = t0 + t1;
            ecode    = ecode >>> chan_shift_i;
            err_d[l] = dsp_pkg::err_t'(ecode) - dsp_pkg::err_t'(codes_d2_q[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            codes_d1_q <= '0;
            codes_d2_q <= '0;
            last_bit_q <= 1'b0;
            error_o    <= '0;
        end else begin
            codes_d1_q <= codes_i;
            codes_d2_q <= codes_d1_q;
            last_bit_q <= bits_i[dsp_pkg::lanes-1];
            error_o    <= err_d;
        end
    end

endmodule

/* dsp_cfg_regs.sv */
`timescale 1ns/1ps

module dsp_cfg_regs (
    input  logic                                                   clk,
    input  logic                                                   rst_i,
    input  logic                                                   cfg_we_i,
    input  dsp_pkg::cfg_addr_t                                     cfg_addr_i,
    input  dsp_pkg::cfg_data_t                                     cfg_wdata_i,
    output dsp_pkg::weight_t [dsp_pkg::lanes-1:0][dsp_pkg::ffe_taps-1:0]  weights_o,
    output dsp_pkg::thresh_t [dsp_pkg::lanes-1:0]                  thresh_o,
    output dsp_pkg::chan_t   [dsp_pkg::lanes-1:0][dsp_pkg::chan_taps-1:0] chan_o,
    output dsp_pkg::shift_t                                        ffe_shift_o,
    output dsp_pkg::shift_t                                        chan_shift_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            weights_o    <= '0;
            thresh_o     <= '0;
            chan_o       <= '0;
            ffe_shift_o  <= '0;
            chan_shift_o <= '0;
        end else if (cfg_we_i) begin
            // FFE weights at lane * ffe_taps + tap
            for (int l = 0; l < dsp_pkg::lanes; l++) begin
                for (int t = 0; t < dsp_pkg::ffe_taps; t++) begin
                    if (cfg_addr_i == dsp_pkg::cfg_addr_t'(dsp_pkg::addr_weight_base
                            + l * dsp_pkg::ffe_taps + t)) begin
                        weights_o[l][t] <= dsp_pkg::weight_t'(
                            cfg_wdata_i[dsp_pkg::weight_w-1:0]);
                    end
                end
            end

            for (int l = 0; l < dsp_pkg::lanes; l++) begin
                if (cfg_addr_i == dsp_pkg::cfg_addr_t'(dsp_pkg::addr_thresh_base + l)) begin
                    thresh_o[l] <= dsp_pkg::thresh_t'(cfg_wdata_i[dsp_pkg::thresh_w-1:0]);
                end
            end

            // Channel taps at lane * chan_taps + tap
            for (int l = 0; l < dsp_pkg::lanes; l++) begin
                for (int t = 0; t < dsp_pkg::chan_taps; t++) begin
                    if (cfg_addr_i == dsp_pkg::cfg_addr_t'(dsp_pkg::addr_chan_base
                            + l * dsp_pkg::chan_taps + t)) begin
                        chan_o[l][t] <= dsp_pkg::chan_t'(cfg_wdata_i[dsp_pkg::chan_w-1:0]);
                    end
                end
            end

            if (cfg_addr_i == dsp_pkg::addr_ffe_shift) begin
                ffe_shift_o <= cfg_wdata_i[dsp_pkg::shift_w-1:0];
            end

            if (cfg_addr_i == dsp_pkg::addr_chan_shift) begin
                chan_shift_o <= cfg_wdata_i[dsp_pkg::shift_w-1:0];
            end
        end
    end

endmodule

/* dsp_datapath_top.sv */
`timescale 1ns/1ps

module dsp_datapath_top (
    input  logic                                        clk,
    input  logic                                        rst_i,
    input  dsp_pkg::code_t    [dsp_pkg::lanes-1:0]      codes_i,
    input  logic                                        cfg_we_i,
    input  dsp_pkg::cfg_addr_t                          cfg_addr_i,
    input  dsp_pkg::cfg_data_t                          cfg_wdata_i,
    output logic              [dsp_pkg::lanes-1:0]      bits_o,
    output dsp_pkg::err_t     [dsp_pkg::lanes-1:0]      error_o,
    output dsp_pkg::flip_t    [dsp_pkg::lanes-1:0]      flip_pos_o
);

    dsp_pkg::code_t   [dsp_pkg::lanes-1:0]                         codes_q;
    dsp_pkg::weight_t [dsp_pkg::lanes-1:0][dsp_pkg::ffe_taps-1:0]  weights;
    dsp_pkg::thresh_t [dsp_pkg::lanes-1:0]                         thresh;
    dsp_pkg::chan_t   [dsp_pkg::lanes-1:0][dsp_pkg::chan_taps-1:0] chan;
    dsp_pkg::shift_t                                               ffe_shift;
    dsp_pkg::shift_t                                               chan_shift;

    // Input word register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            codes_q <= '0;
        end else begin
            codes_q <= codes_i;
        end
    end

    dsp_cfg_regs dsp_cfg_regs_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_wdata_i  (cfg_wdata_i),
        .weights_o    (weights),
        .thresh_o     (thresh),
        .chan_o       (chan),
        .ffe_shift_o  (ffe_shift),
        .chan_shift_o (chan_shift)
    );

    ffe_slicer ffe_slicer_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .codes_i      (codes_q),
        .weights_i    (weights),
        .thresh_i     (thresh),
        .ffe_shift_i  (ffe_shift),
        .bits_o       (bits_o)
    );

    channel_error channel_error_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .codes_i      (codes_q),
        .bits_i       (bits_o),
        .chan_i       (chan),
        .chan_shift_i (chan_shift),
        .error_o      (error_o)
    );

    sliding_detector sliding_detector_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .bits_i       (bits_o),
        .error_i      (error_o),
        .chan_i       (chan),
        .chan_shift_i (chan_shift),
        .flip_pos_o   (flip_pos_o)
    );

endmodule

/* dsp_pkg.sv */
package dsp_pkg;

    // Stream geometry
    localparam int lanes     = 4;
    localparam int ffe_taps  = 3;
    localparam int chan_taps = 2;

    // Field widths
    localparam int code_w   = 8;
    localparam int weight_w = 8;
    localparam int est_w    = 10;
    localparam int thresh_w = 10;
    localparam int chan_w   = 8;
    localparam int ecode_w  = 10;
    localparam int err_w    = 11;
    localparam int shift_w  = 4;
    localparam int flip_w   = 2;
    localparam int addr_w   = 6;
    localparam int data_w   = 16;

    // Internal arithmetic widths
    localparam int ffe_sum_w   = code_w + weight_w + 2;
    localparam int det_diff_w  = err_w + 1;
    localparam int det_cost_w  = 2 * det_diff_w;

    // Estimate saturation limits
    localparam int est_max = 2 ** (est_w - 1) - 1;
    localparam int est_min = -(2 ** (est_w - 1));

    typedef logic signed [code_w-1:0]   code_t;
    typedef logic signed [weight_w-1:0] weight_t;
    typedef logic signed [est_w-1:0]    est_t;
    typedef logic signed [thresh_w-1:0] thresh_t;
    typedef logic signed [chan_w-1:0]   chan_t;
    typedef logic signed [ecode_w-1:0]  ecode_t;
    typedef logic signed [err_w-1:0]    err_t;
    typedef logic [shift_w-1:0]         shift_t;
    typedef logic [flip_w-1:0]          flip_t;
    typedef logic [addr_w-1:0]          cfg_addr_t;
    typedef logic [data_w-1:0]          cfg_data_t;

    // Detector results
    localparam flip_t flip_keep = 2'd0;
    localparam flip_t flip_cur  = 2'd1;
    localparam flip_t flip_prev = 2'd2;

    // Register map
    localparam cfg_addr_t addr_weight_base = 6'd0;
    localparam cfg_addr_t addr_thresh_base = 6'd16;
    localparam cfg_addr_t addr_chan_base   = 6'd24;
    localparam cfg_addr_t addr_ffe_shift   = 6'd32;
    localparam cfg_addr_t addr_chan_shift  = 6'd33;

endpackage

/* ffe_slicer.sv */
`timescale 1ns/1ps

module ffe_slicer (
    input  logic                                                          clk,
    input  logic                                                          rst_i,
    input  dsp_pkg::code_t   [dsp_pkg::lanes-1:0]                         codes_i,
    input  dsp_pkg::weight_t [dsp_pkg::lanes-1:0][dsp_pkg::ffe_taps-1:0]  weights_i,
    input  dsp_pkg::thresh_t [dsp_pkg::lanes-1:0]                         thresh_i,
    input  dsp_pkg::shift_t                                               ffe_shift_i,
    output logic             [dsp_pkg::lanes-1:0]                         bits_o
);

    localparam int hist_len = dsp_pkg::ffe_taps - 1;

    // Tail of the previous word with the oldest sample in entry 0
    dsp_pkg::code_t [hist_len-1:0] hist_q;

    dsp_pkg::code_t win [hist_len+dsp_pkg::lanes];

    dsp_pkg::est_t [dsp_pkg::lanes-1:0] est_d;
    dsp_pkg::est_t [dsp_pkg::lanes-1:0] est_q;

    always_comb begin
        for (int k = 0; k < hist_len; k++) begin
            win[k] = hist_q[k];
        end
        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            win[hist_len+l] = codes_i[l];
        end
    end

    always_comb begin
        logic signed [dsp_pkg::ffe_sum_w-1:0] acc;
        logic signed [dsp_pkg::ffe_sum_w-1:0] shifted;
        dsp_pkg::weight_t w;
        dsp_pkg::code_t   x;

        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            acc = '0;
            for (int t = 0; t < dsp_pkg::ffe_taps; t++) begin
                w   = weights_i[l][t];
                x   = win[hist_len+l-t];
                acc = acc + w * x;
            end
            shifted = acc >>> ffe_shift_i;

            if (shifted > dsp_pkg::est_max) begin
                est_d[l] = dsp_pkg::est_t'(dsp_pkg::est_max);
            end else if (shifted < dsp_pkg::est_min) begin
                est_d[l] = dsp_pkg::est_t'(dsp_pkg::est_min);
            end else begin
                est_d[l] = shifted[dsp_pkg::est_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hist_q <= '0;
            est_q  <= '0;
            bits_o <= '0;
        end else begin
            hist_q <= codes_i[dsp_pkg::lanes-1:dsp_pkg::lanes-hist_len];
            est_q  <= est_d;
            for (int l = 0; l < dsp_pkg::lanes; l++) begin
                // Slicer ties resolve to 1
                bits_o[l] <= (est_q[l] >= thresh_i[l]);
            end
        end
    end

endmodule

/* filelist.f */
dsp_pkg.sv
dsp_cfg_regs.sv
ffe_slicer.sv
channel_error.sv
sliding_detector.sv
dsp_datapath_top.sv
tb_clock_gen.sv
tb_dsp_datapath.sv

/* sliding_detector.sv */
`timescale 1ns/1ps

module sliding_detector (
    input  logic                                                          clk,
    input  logic                                                          rst_i,
    input  logic             [dsp_pkg::lanes-1:0]                         bits_i,
    input  dsp_pkg::err_t    [dsp_pkg::lanes-1:0]                         error_i,
    input  dsp_pkg::chan_t   [dsp_pkg::lanes-1:0][dsp_pkg::chan_taps-1:0] chan_i,
    input  dsp_pkg::shift_t                                               chan_shift_i,
    output dsp_pkg::flip_t   [dsp_pkg::lanes-1:0]                         flip_pos_o
);

    // Bits lead the error by one register
    logic [dsp_pkg::lanes-1:0] bits_q;
    logic                      last_bit_q;

    logic [dsp_pkg::lanes-1:0] prev_bits;

    dsp_pkg::flip_t [dsp_pkg::lanes-1:0] flip_d;

    always_comb begin
        prev_bits[0] = last_bit_q;
        for (int l = 1; l < dsp_pkg::lanes; l++) begin
            prev_bits[l] = bits_q[l-1];
        end
    end

    always_comb begin
        dsp_pkg::chan_t g0;
        dsp_pkg::chan_t g1;
        logic signed [dsp_pkg::det_diff_w-1:0] e;
        logic signed [dsp_pkg::det_diff_w-1:0] inj0;
        logic signed [dsp_pkg::det_diff_w-1:0] inj1;
        logic signed [dsp_pkg::det_diff_w-1:0] d1;
        logic signed [dsp_pkg::det_diff_w-1:0] d2;
        logic signed [dsp_pkg::det_cost_w-1:0] cost0;
        logic signed [dsp_pkg::det_cost_w-1:0] cost1;
        logic signed [dsp_pkg::det_cost_w-1:0] cost2;
        logic signed [dsp_pkg::det_cost_w-1:0] best;

        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            g0 = chan_i[l][0] >>> chan_shift_i;
            g1 = chan_i[l][1] >>> chan_shift_i;
            e  = error_i[l];

            // Error change caused by flipping a bit of sign s is -2*s*g
            inj0 = 2 * g0;
            inj1 = 2 * g1;
            d1   = bits_q[l]    ? e - inj0 : e + inj0;
            d2   = prev_bits[l] ? e - inj1 : e + inj1;

            cost0 = e * e;
            cost1 = d1 * d1;
            cost2 = d2 * d2;

            // Strict compares keep the lower index on ties
            flip_d[l] = dsp_pkg::flip_keep;
            best      = cost0;
            if (cost1 < best) begin
                flip_d[l] = dsp_pkg::flip_cur;
                best      = cost1;
            end
            if (cost2 < best) begin
                flip_d[l] = dsp_pkg::flip_prev;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bits_q     <= '0;
            last_bit_q <= 1'b0;
            flip_pos_o <= '0;
        end else begin
            bits_q     <= bits_i;
            last_bit_q <= bits_q[dsp_pkg::lanes-1];
            flip_pos_o <= flip_d;
        end
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

endmodule

/* tb_dsp_datapath.sv */
`timescale 1ns/1ps

module tb_dsp_datapath;

    localparam int ofs        = 4;
    localparam int depth      = 512;
    localparam int reg_count  = 34;
    localparam int stream_len = 30;
    localparam int clk_ns     = 4;
    // Cycles of reset, config, two FFE rounds, channel, detector and reconfig
    localparam int total_cycles = 4 + (10 + stream_len) + 2 * (17 + stream_len)
                                + (9 + stream_len) + (38 + stream_len) + stream_len;
    localparam int margin_cycles = 50;

    logic                                clk;
    logic                                rst;
    dsp_pkg::code_t [dsp_pkg::lanes-1:0] codes;
    logic                                cfg_we;
    dsp_pkg::cfg_addr_t                  cfg_addr;
    dsp_pkg::cfg_data_t                  cfg_wdata;
    logic           [dsp_pkg::lanes-1:0] bits;
    dsp_pkg::err_t  [dsp_pkg::lanes-1:0] error;
    dsp_pkg::flip_t [dsp_pkg::lanes-1:0] flip_pos;

    logic [31:0] lcg_state;
    string       test_name;
    int          cur;

    // Reference model indexed by clock edge plus ofs
    int                      w_m    [depth][dsp_pkg::lanes];
    int                      cfg_m  [depth][reg_count];
    int                      est_m  [depth][dsp_pkg::lanes];
    int                      err_m  [depth][dsp_pkg::lanes];
    int                      flip_m [depth][dsp_pkg::lanes];
    bit [dsp_pkg::lanes-1:0] bits_m [depth];

    tb_clock_gen tb_clock_gen_inst (
        .clk_o (clk)
    );

    dsp_datapath_top dsp_datapath_top_inst (
        .clk         (clk),
        .rst_i       (rst),
        .codes_i     (codes),
        .cfg_we_i    (cfg_we),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .bits_o      (bits),
        .error_o     (error),
        .flip_pos_o  (flip_pos)
    );

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w[31:16] = rand16();
        w[15:0]  = rand16();
        return w;
    endfunction

    function automatic bit is_mapped(input int addr);
        return (addr < 12) || (addr >= 16 && addr < 20) || (addr >= 24 && addr <= 33);
    endfunction

    function automatic int field_value(input int addr, input logic [15:0] data);
        if (addr >= 16 && addr < 20) begin
            return int'($signed(data[9:0]));
        end else if (addr >= 32) begin
            return int'(data[3:0]);
        end
        return int'($signed(data[7:0]));
    endfunction

    function automatic int sgn(input bit b);
        return b ? 1 : -1;
    endfunction

    task automatic expect_equal(input string what, input integer expected, input integer actual);
        if (expected !== actual) begin
            $display("Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // Register values seen at edge i come from the config held after edge i-1
    task automatic model_edge(input int i);
        int c;
        int acc;
        int j;
        int x;
        int ec;
        int ev;
        int g0;
        int g1;
        int cost0;
        int cost1;
        int cost2;
        bit pb;
        c = i - 1;
        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            acc = 0;
            for (int t = 0; t < dsp_pkg::ffe_taps; t++) begin
                j   = l - t;
                x   = (j >= 0) ? w_m[i-1][j] : w_m[i-2][dsp_pkg::lanes+j];
                acc = acc + cfg_m[c][l*3+t] * x;
            end
            acc = acc >>> cfg_m[c][32];
            acc = (acc > 511) ? 511 : ((acc < -512) ? -512 : acc);
            est_m[i][l]  = acc;
            bits_m[i][l] = (est_m[i-1][l] >= cfg_m[c][16+l]);

            // Expected code uses the bits of the word that left the slicer last edge
            pb = (l == 0) ? bits_m[i-2][3] : bits_m[i-1][l-1];
            ec = (sgn(bits_m[i-1][l]) * cfg_m[c][24+l*2] + sgn(pb) * cfg_m[c][25+l*2])
                 >>> cfg_m[c][33];
            err_m[i][l] = ec - w_m[i-3][l];

            pb    = (l == 0) ? bits_m[i-3][3] : bits_m[i-2][l-1];
            g0    = cfg_m[c][24+l*2] >>> cfg_m[c][33];
            g1    = cfg_m[c][25+l*2] >>> cfg_m[c][33];
            ev    = err_m[i-1][l];
            cost0 = ev * ev;
            cost1 = (ev - 2 * sgn(bits_m[i-2][l]) * g0) ** 2;
            cost2 = (ev - 2 * sgn(pb) * g1) ** 2;
            flip_m[i][l] = 0;
            if (cost1 < cost0) begin
                flip_m[i][l] = 1;
            end
            if (cost2 < cost0 && cost2 < cost1) begin
                flip_m[i][l] = 2;
            end
        end
    endtask

    task automatic check_outputs(input int i);
        expect_equal("bits", bits_m[i], bits);
        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            expect_equal($sformatf("error[%0d]", l), err_m[i][l], $signed(error[l]));
            expect_equal($sformatf("flip_pos[%0d]", l), flip_m[i][l], flip_pos[l]);
        end
    endtask

    // Drive a word and an optional write for one clock and check all outputs
    task automatic step(input logic [31:0] word, input bit we, input int addr,
                        input logic [15:0] data);
        int i;
        i = cur + 1;
        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            w_m[i][l] = int'($signed(word[8*l +: 8]));
        end
        for (int a = 0; a < reg_count; a++) begin
            cfg_m[i][a] = cfg_m[i-1][a];
        end
        if (we && is_mapped(addr)) begin
            cfg_m[i][addr] = field_value(addr, data);
        end
        codes     = word;
        cfg_we    = we;
        cfg_addr  = dsp_pkg::cfg_addr_t'(addr);
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cur = i;
        model_edge(i);
        check_outputs(i);
    endtask

    task automatic write_reg(input int addr, input logic [15:0] data);
        step(random_word(), 1'b1, addr, data);
    endtask

    task automatic check_reset();
        test_name = "reset";
        rst = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
            expect_equal("bits", 0, bits);
            for (int l = 0; l < dsp_pkg::lanes; l++) begin
                expect_equal($sformatf("error[%0d]", l), 0, $signed(error[l]));
                expect_equal($sformatf("flip_pos[%0d]", l), 0, flip_pos[l]);
            end
        end
        rst = 1'b0;
        cur = ofs - 1;
    endtask

    task automatic config_identity();
        int         unmapped [6];
        logic [3:0] signs;
        unmapped  = '{12, 15, 20, 23, 34, 63};
        test_name = "config";
        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            write_reg(l * dsp_pkg::ffe_taps, 16'd1);
        end
        for (int k = 0; k < 6; k++) begin
            write_reg(unmapped[k], 16'hffff);
        end
        for (int k = 0; k < stream_len; k++) begin
            step(random_word(), 1'b0, 0, 16'd0);
            // Bits show the sign of the word sampled two edges earlier
            if (k >= 2) begin
                for (int l = 0; l < dsp_pkg::lanes; l++) begin
                    signs[l] = (w_m[cur-2][l] >= 0);
                end
                expect_equal("sign rule", signs, bits);
            end
        end
    endtask

    task automatic ffe_history();
        test_name = "ffe";
        for (int r = 0; r < 2; r++) begin
            for (int a = 0; a < 12; a++) begin
                write_reg(a, rand16());
            end
            for (int l = 0; l < dsp_pkg::lanes; l++) begin
                write_reg(16 + l, rand16());
            end
            // Shift 0 in the first round drives most sums into saturation
            write_reg(32, (r == 0) ? 16'd0 : 16'(2 + rand16() % 4));
            repeat (stream_len) step(random_word(), 1'b0, 0, 16'd0);
        end
    endtask

    task automatic channel_residual();
        test_name = "channel";
        for (int a = 0; a < 8; a++) begin
            write_reg(24 + a, rand16());
        end
        write_reg(33, 16'(rand16() % 4));
        repeat (stream_len) step(random_word(), 1'b0, 0, 16'd0);
    endtask

    task automatic detector_argmin();
        logic [7:0] crafted [4];
        crafted   = '{8'd16, 8'd8, 8'd40, 8'hf8};
        test_name = "detector";
        for (int a = 0; a < 12; a++) begin
            write_reg(a, (a % 3 == 0) ? 16'd1 : 16'd0);
        end
        for (int l = 0; l < dsp_pkg::lanes; l++) begin
            write_reg(16 + l, 16'd0);
        end
        write_reg(32, 16'd0);
        // With all taps at 16 a code of 16 ties all three costs and a code of 8 ties both flips
        for (int a = 0; a < 8; a++) begin
            write_reg(24 + a, 16'd16);
        end
        write_reg(33, 16'd0);
        for (int p = 0; p < 4; p++) begin
            repeat (3) step({4{crafted[p]}}, 1'b0, 0, 16'd0);
        end
        repeat (stream_len) step(random_word(), 1'b0, 0, 16'd0);
    endtask

    task automatic midstream_threshold();
        logic [15:0] thr;
        test_name = "reconfig";
        for (int k = 0; k < stream_len; k++) begin
            if (k >= 8 && k < 8 + dsp_pkg::lanes) begin
                thr = 16'(int'(rand16() % 64) - 32);
                step(random_word(), 1'b1, 16 + k - 8, thr);
            end else begin
                step(random_word(), 1'b0, 0, 16'd0);
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        codes     = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        lcg_state = 32'hd6bce579;
        cur       = 0;
        check_reset();
        config_identity();
        ffe_history();
        channel_residual();
        detector_argmin();
        midstream_threshold();
        $display("** PASS **");
        $finish;
    end

    initial begin
        #((total_cycles + margin_cycles) * clk_ns);
        $display("Timeout: tests did not finish within %0d cycles",
                 total_cycles + margin_cycles);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule
